// ==== hdl/ulaPkg.sv ====
package ulaPkg;

   //////////////////////////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////////////////////////

   // CPU data bus, register contents and palette entries
   typedef logic [7:0] byteT;

   // Z80 I/O address, full 16 bits
   typedef logic [15:0] ioAddrT;

   // Border colour in G, R, B order
   typedef logic [2:0] borderT;

   // ULAplus palette index, 64 entries
   typedef logic [5:0] palIdxT;

   // Output colour GGGRRRBBB
   typedef logic [8:0] colourT;

   // Which source drives the CPU bus during an I/O read
   typedef enum logic [2:0] {
      rsNone,
      rsKeyboard,
      rsPalSelect,
      rsPalEntry,
      rsConfig,
      rsTimex
   } readSelT;

   //////////////////////////////////////////////////////////////////////
   // I/O ports
   //////////////////////////////////////////////////////////////////////

   // ULAplus ports decode the whole address
   localparam ioAddrT portUlaplusSel  = 16'hBF3B;
   localparam ioAddrT portUlaplusData = 16'hFF3B;

   // Timex ports match on the low byte only
   localparam byteT portTimex    = 8'hFF;
   localparam byteT portTimexMmu = 8'hF4;

   //////////////////////////////////////////////////////////////////////
   // Colour levels
   //////////////////////////////////////////////////////////////////////

   // Intensity of one channel in the standard palette
   localparam logic [2:0] levelNone = 3'b000;
   localparam logic [2:0] levelHalf = 3'b101;
   localparam logic [2:0] levelFull = 3'b111;

endpackage

// ==== hdl/ulaPortDecode.sv ====
`timescale 1ns/1ns

module ulaPortDecode import ulaPkg::*; (
   input  ioAddrT   addr,
   input  logic     ioReqN,
   input  logic     rdN,
   input  logic     wrN,
   input  logic     cfgMode,
   input  logic     timexMmuEn,
   input  logic     timexScrDis,
   input  logic     ulaplusDis,
   output logic     feWr,
   output logic     timexWr,
   output logic     palSelWr,
   output logic     palDataWr,
   output logic     configWr,
   output readSelT  readSel
);

   logic hitFe;
   logic hitTimex;
   logic hitPalSel;
   logic hitPalData;

   // Any even port is FE, except F4 while the Timex MMU owns it
   assign hitFe = !addr[0] && !(timexMmuEn && addr[7:0] == portTimexMmu);
   assign hitTimex = (addr[7:0] == portTimex) && !timexScrDis;
   assign hitPalSel = (addr == portUlaplusSel) && !ulaplusDis;
   assign hitPalData = (addr == portUlaplusData) && !ulaplusDis;

   // Write strobes, first match wins
   always_comb begin
      feWr = 1'b0;
      timexWr = 1'b0;
      palSelWr = 1'b0;
      palDataWr = 1'b0;
      configWr = 1'b0;
      if (!ioReqN && !wrN) begin
         if (hitFe)
            feWr = 1'b1;
         else if (hitTimex)
            timexWr = 1'b1;
         else if (hitPalSel)
            palSelWr = 1'b1;
         else if (hitPalData) begin
            // Select bit 6 steers the data port to the config bit
            if (cfgMode)
               configWr = 1'b1;
            else
               palDataWr = 1'b1;
         end
      end
   end

   // Read source, same priority as the writes
   always_comb begin
      readSel = rsNone;
      if (!ioReqN && !rdN) begin
         if (hitFe)
            readSel = rsKeyboard;
         else if (hitTimex && timexMmuEn)
            readSel = rsTimex;
         else if (hitPalSel)
            readSel = rsPalSelect;
         else if (hitPalData)
            readSel = cfgMode ? rsConfig : rsPalEntry;
      end
   end

   // An I/O cycle loads one register or selects one read source, never both
   oneWriteStrobe: assert final ($onehot0({feWr, timexWr, palSelWr, palDataWr, configWr,
                                           readSel != rsNone}));

endmodule

// ==== hdl/ulaControlRegs.sv ====
`timescale 1ns/1ns

module ulaControlRegs import ulaPkg::*; #(
   parameter int FlashBits = 5
) (
   input  logic     clkregs,
   input  logic     rst_n,
   input  byteT     dataIn,
   input  logic     feWr,
   input  logic     timexWr,
   input  logic     palSelWr,
   input  logic     palDataWr,
   input  logic     configWr,
   input  readSelT  readSel,
   input  logic [4:0] kbd,
   input  logic     ear,
   input  logic     issue2Kbd,
   input  logic     timexMmuEn,
   input  logic     frameStrobe,
   input  byteT     palEntryCpu,
   output borderT   border,
   output logic     mic,
   output logic     spk,
   output logic     docExt,
   output palIdxT   palIdx,
   output logic     cfgMode,
   output logic     ulaplusEn,
   output logic     flashPhase,
   output byteT     dataOut
);

   byteT                 timexReg;
   logic [6:0]           palSelect;
   logic                 configBit;
   logic [FlashBits-1:0] flashCnt;
   logic                 earAltered;

   //////////////////////////////////////////////////////////////////////
   // CPU-written registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clkregs) begin
      if (!rst_n) begin
         // Border comes up red
         border <= 3'b010;
         mic <= 1'b0;
         spk <= 1'b0;
         timexReg <= '0;
         palSelect <= '0;
         configBit <= 1'b0;
         flashCnt <= '0;
      end else begin
         if (feWr) begin
            border <= dataIn[2:0];
            mic <= dataIn[3];
            spk <= dataIn[4];
         end
         if (timexWr)
            timexReg <= dataIn;
         if (palSelWr)
            palSelect <= dataIn[6:0];
         if (configWr)
            configBit <= dataIn[0];
         // One step per frame
         if (frameStrobe)
            flashCnt <= flashCnt + 1'b1;
      end
   end

   assign docExt = timexMmuEn & timexReg[7];
   assign palIdx = palSelect[5:0];
   assign cfgMode = palSelect[6];
   assign ulaplusEn = configBit;
   assign flashPhase = flashCnt[FlashBits-1];

   //////////////////////////////////////////////////////////////////////
   // CPU read data
   //////////////////////////////////////////////////////////////////////

   // Issue 2 boards also couple MIC back into EAR
   assign earAltered = issue2Kbd ? ear ^ (spk | mic) : ear ^ spk;

   always_comb begin
      case (readSel)
         rsKeyboard:  dataOut = {1'b1, earAltered, 1'b1, kbd};
         rsPalSelect: dataOut = {1'b0, palSelect};
         rsPalEntry:  dataOut = palEntryCpu;
         rsConfig:    dataOut = {7'b0000000, configBit};
         rsTimex:     dataOut = timexReg;
         default:     dataOut = 8'hFF;
      endcase
   end

   // Decode must always present a legal source
   readSelKnown: assert property (@(posedge clkregs) disable iff (!rst_n)
      !$isunknown(readSel));

endmodule

// ==== hdl/ulaPaletteRam.sv ====
`timescale 1ns/1ns

module ulaPaletteRam import ulaPkg::*; (
   input  logic   clkregs,
   input  logic   palDataWr,
   input  byteT   dataIn,
   input  palIdxT palIdx,
   input  palIdxT paperIdx,
   input  palIdxT inkIdx,
   output byteT   paperEntry,
   output byteT   inkEntry,
   output byteT   palEntryCpu
);

   // 64 GGGRRRBB entries
   byteT mem [64];

   // CPU side write through the data port
   always_ff @(posedge clkregs) begin
      if (palDataWr)
         mem[palIdx] <= dataIn;
   end

   // Video reads for paper and ink
   assign paperEntry = mem[paperIdx];
   assign inkEntry = mem[inkIdx];

   // CPU read-back of the selected entry
   assign palEntryCpu = mem[palIdx];

endmodule

// ==== hdl/ulaColourOut.sv ====
`timescale 1ns/1ns

module ulaColourOut import ulaPkg::*; (
   input  logic   clkregs,
   input  logic   rst_n,
   input  byteT   attr,
   input  logic   pixel,
   input  logic   flashPhase,
   input  logic   ulaplusEn,
   input  byteT   paperEntry,
   input  byteT   inkEntry,
   output palIdxT paperIdx,
   output palIdxT inkIdx,
   output colourT rgb
);

   logic   pixelFlash;
   logic   bright;
   borderT stdGrb;
   colourT stdColour;
   byteT   plusEntry;
   colourT plusColour;

   // One channel of the standard palette
   function automatic logic [2:0] channelLevel(input logic on, input logic hi);
      logic [2:0] lvl;
      if (!on)
         lvl = levelNone;
      else if (hi)
         lvl = levelFull;
      else
         lvl = levelHalf;
      return lvl;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Standard path
   //////////////////////////////////////////////////////////////////////

   // Flash swaps ink and paper on alternate phases
   assign pixelFlash = pixel ^ (attr[7] & flashPhase);
   assign bright = attr[6];
   assign stdGrb = pixelFlash ? attr[2:0] : attr[5:3];

   assign stdColour = {channelLevel(stdGrb[2], bright),
                       channelLevel(stdGrb[1], bright),
                       channelLevel(stdGrb[0], bright)};

   //////////////////////////////////////////////////////////////////////
   // ULAplus path
   //////////////////////////////////////////////////////////////////////

   // Attr 7:6 picks one of four 16-entry CLUTs
   assign paperIdx = {attr[7:6], 1'b1, attr[5:3]};
   assign inkIdx = {attr[7:6], 1'b0, attr[2:0]};

   assign plusEntry = pixel ? inkEntry : paperEntry;

   // Blue is stored as two bits, B1 repeats as the low bit
   assign plusColour = {plusEntry, plusEntry[1]};

   // Output register
   always_ff @(posedge clkregs) begin
      if (!rst_n)
         rgb <= '0;
      else if (ulaplusEn)
         rgb <= plusColour;
      else
         rgb <= stdColour;
   end

   // Palette must be loaded before ULAplus mode is switched on
   rgbKnown: assert property (@(posedge clkregs) disable iff (!rst_n)
      !$isunknown(rgb));

endmodule

// ==== hdl/ulaTop.sv ====
`timescale 1ns/1ns

module ulaTop import ulaPkg::*; #(
   parameter int FlashBits = 5
) (
   input  logic       clkregs,
   input  logic       rst_n,
   input  ioAddrT     addr,
   input  logic       ioReqN,
   input  logic       rdN,
   input  logic       wrN,
   input  byteT       dataIn,
   input  logic [4:0] kbd,
   input  logic       ear,
   input  logic       issue2Kbd,
   input  logic       timexMmuEn,
   input  logic       timexScrDis,
   input  logic       ulaplusDis,
   input  logic       frameStrobe,
   input  byteT       attr,
   input  logic       pixel,
   output byteT       dataOut,
   output borderT     border,
   output logic       mic,
   output logic       spk,
   output logic       docExt,
   output colourT     rgb
);

   logic    feWr;
   logic    timexWr;
   logic    palSelWr;
   logic    palDataWr;
   logic    configWr;
   readSelT readSel;
   logic    cfgMode;
   logic    ulaplusEn;
   logic    flashPhase;
   palIdxT  palIdx;
   palIdxT  paperIdx;
   palIdxT  inkIdx;
   byteT    palEntryCpu;
   byteT    paperEntry;
   byteT    inkEntry;

   //////////////////////////////////////////////////////////////////////
   // CPU side
   //////////////////////////////////////////////////////////////////////

   ulaPortDecode decode (
      .addr(addr), .ioReqN(ioReqN), .rdN(rdN), .wrN(wrN),
      .cfgMode(cfgMode), .timexMmuEn(timexMmuEn),
      .timexScrDis(timexScrDis), .ulaplusDis(ulaplusDis),
      .feWr(feWr), .timexWr(timexWr), .palSelWr(palSelWr),
      .palDataWr(palDataWr), .configWr(configWr), .readSel(readSel)
   );

   ulaControlRegs #(.FlashBits(FlashBits)) regs (
      .clkregs(clkregs), .rst_n(rst_n), .dataIn(dataIn),
      .feWr(feWr), .timexWr(timexWr), .palSelWr(palSelWr),
      .palDataWr(palDataWr), .configWr(configWr), .readSel(readSel),
      .kbd(kbd), .ear(ear), .issue2Kbd(issue2Kbd), .timexMmuEn(timexMmuEn),
      .frameStrobe(frameStrobe), .palEntryCpu(palEntryCpu),
      .border(border), .mic(mic), .spk(spk), .docExt(docExt),
      .palIdx(palIdx), .cfgMode(cfgMode), .ulaplusEn(ulaplusEn),
      .flashPhase(flashPhase), .dataOut(dataOut)
   );

   //////////////////////////////////////////////////////////////////////
   // Video side
   //////////////////////////////////////////////////////////////////////

   ulaPaletteRam palette (
      .clkregs(clkregs), .palDataWr(palDataWr), .dataIn(dataIn),
      .palIdx(palIdx), .paperIdx(paperIdx), .inkIdx(inkIdx),
      .paperEntry(paperEntry), .inkEntry(inkEntry), .palEntryCpu(palEntryCpu)
   );

   ulaColourOut colour (
      .clkregs(clkregs), .rst_n(rst_n), .attr(attr), .pixel(pixel),
      .flashPhase(flashPhase), .ulaplusEn(ulaplusEn),
      .paperEntry(paperEntry), .inkEntry(inkEntry),
      .paperIdx(paperIdx), .inkIdx(inkIdx), .rgb(rgb)
   );

endmodule

// ==== tb/ulaTb.sv ====
`timescale 1ns/1ns

module ulaTb import ulaPkg::*; ();

   //////////////////////////////////////////////////////////////////////
   // Step table types
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      opWrite,
      opRead,
      opNoIo,
      opBorder,
      opDocExt,
      opColour,
      opFrames,
      opPalFill,
      opPalCheck,
      opPlusColour
   } opT;

   // Option levels as {issue2Kbd, timexMmuEn, timexScrDis, ulaplusDis}
   typedef struct packed {
      opT         op;
      ioAddrT     addr;
      byteT       data;
      logic [3:0] opts;
      colourT     exp;
   } stepT;

   localparam logic [3:0] optNone = 4'b0000;
   localparam logic [3:0] optIssue2 = 4'b1000;
   localparam logic [3:0] optMmu = 4'b0100;
   localparam logic [3:0] optScrDis = 4'b0010;
   localparam logic [3:0] optPlusDis = 4'b0001;
   localparam int frameTimeout = 64;

   logic       clkregs;
   logic       rst_n;
   ioAddrT     addr;
   logic       ioReqN;
   logic       rdN;
   logic       wrN;
   byteT       dataIn;
   logic [4:0] kbd;
   logic       ear;
   logic       issue2Kbd;
   logic       timexMmuEn;
   logic       timexScrDis;
   logic       ulaplusDis;
   logic       frameStrobe;
   byteT       attr;
   logic       pixel;
   byteT       dataOut;
   borderT     border;
   logic       mic;
   logic       spk;
   logic       docExt;
   colourT     rgb;

   stepT       steps[$];
   byteT       palModel [64];
   logic [3:0] curOpts;
   integer     seed;

   ulaTop #(.FlashBits(5)) DUT (
      .clkregs(clkregs), .rst_n(rst_n), .addr(addr), .ioReqN(ioReqN),
      .rdN(rdN), .wrN(wrN), .dataIn(dataIn), .kbd(kbd), .ear(ear),
      .issue2Kbd(issue2Kbd), .timexMmuEn(timexMmuEn),
      .timexScrDis(timexScrDis), .ulaplusDis(ulaplusDis),
      .frameStrobe(frameStrobe), .attr(attr), .pixel(pixel),
      .dataOut(dataOut), .border(border), .mic(mic), .spk(spk),
      .docExt(docExt), .rgb(rgb)
   );

   always #2 clkregs = ~clkregs;

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   task automatic checkByte(input string name, input byteT act, input byteT exp);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         $display("sim failed");
         $fatal(1, "stopping on first mismatch");
      end
   endtask

   task automatic checkBorder(input string name, input borderT act, input borderT exp);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
         $display("sim failed");
         $fatal(1, "stopping on first mismatch");
      end
   endtask

   task automatic checkBit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
         $display("sim failed");
         $fatal(1, "stopping on first mismatch");
      end
   endtask

   task automatic checkColour(input string name, input colourT act, input colourT exp);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         $display("sim failed");
         $fatal(1, "stopping on first mismatch");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus cycles
   //////////////////////////////////////////////////////////////////////

   // One clock of CPU bus activity, options come from the current step
   task automatic cpuCycle(input ioAddrT a, input byteT d, input logic isRd, input logic isWr);
      @(posedge clkregs);
      addr <= a;
      dataIn <= d;
      ioReqN <= !(isRd || isWr);
      rdN <= !isRd;
      wrN <= !isWr;
      issue2Kbd <= curOpts[3];
      timexMmuEn <= curOpts[2];
      timexScrDis <= curOpts[1];
      ulaplusDis <= curOpts[0];
   endtask

   task automatic pulseFrames(input int count);
      int pulses;
      int cycles;
      pulses = 0;
      cycles = 0;
      while (pulses < count) begin
         if (cycles >= frameTimeout) begin
            $display("Frame pulses did not finish within %0d cycles", frameTimeout);
            $display("sim failed");
            $fatal(1, "frame loop timeout");
         end else begin
            cpuCycle(16'h0000, 8'h00, 1'b0, 1'b0);
            frameStrobe <= 1'b1;
            pulses++;
            cycles++;
         end
      end
      cpuCycle(16'h0000, 8'h00, 1'b0, 1'b0);
      frameStrobe <= 1'b0;
   endtask

   // Load every palette entry with random data and keep a copy
   task automatic fillPalette();
      byteT v;
      for (int i = 0; i < 64; i++) begin
         v = $random(seed);
         palModel[i] = v;
         cpuCycle(portUlaplusSel, byteT'(i), 1'b0, 1'b1);
         cpuCycle(portUlaplusData, v, 1'b0, 1'b1);
      end
   endtask

   // ULAplus colour from the palette copy
   function automatic colourT plusExpect(input byteT at, input logic px);
      palIdxT idx;
      byteT   entry;
      if (px)
         idx = {at[7:6], 1'b0, at[2:0]};
      else
         idx = {at[7:6], 1'b1, at[5:3]};
      entry = palModel[idx];
      return {entry, entry[1]};
   endfunction

   function automatic void addStep(input opT op, input ioAddrT a, input byteT d,
                                   input logic [3:0] o, input colourT e);
      stepT s;
      s.op = op;
      s.addr = a;
      s.data = d;
      s.opts = o;
      s.exp = e;
      steps.push_back(s);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////////////////////////

   task automatic buildTable();
      // Port FE writes, border comes up red
      addStep(opBorder, 16'h0000, 8'h00, optNone, 9'h002);
      addStep(opWrite, 16'h00FE, 8'h1D, optNone, 9'h000);
      addStep(opBorder, 16'h0000, 8'h00, optNone, 9'h01D);
      addStep(opWrite, 16'h7FFE, 8'h03, optNone, 9'h000);
      addStep(opBorder, 16'h0000, 8'h00, optNone, 9'h003);
      addStep(opWrite, {8'h00, portTimexMmu}, 8'h1F, optMmu, 9'h000);
      addStep(opBorder, 16'h0000, 8'h00, optMmu, 9'h003);
      addStep(opWrite, {8'h00, portTimexMmu}, 8'h06, optNone, 9'h000);
      addStep(opBorder, 16'h0000, 8'h00, optNone, 9'h006);
      // Keyboard reads with MIC high, SPK low
      addStep(opWrite, 16'h00FE, 8'h08, optNone, 9'h000);
      addStep(opBorder, 16'h0000, 8'h00, optNone, 9'h008);
      addStep(opRead, 16'hFEFE, 8'h15, optIssue2, 9'h0F5);
      addStep(opRead, 16'hFEFE, 8'h15, optNone, 9'h0B5);
      addStep(opRead, 16'h7FFE, 8'h2A, optNone, 9'h0EA);
      addStep(opNoIo, 16'h0000, 8'h00, optNone, 9'h0FF);
      addStep(opRead, 16'h00FD, 8'h00, optNone, 9'h0FF);
      // ULAplus palette and select
      addStep(opPalFill, 16'h0000, 8'h00, optNone, 9'h000);
      addStep(opPalCheck, 16'h0000, 8'd0, optNone, 9'h000);
      addStep(opPalCheck, 16'h0000, 8'd17, optNone, 9'h000);
      addStep(opPalCheck, 16'h0000, 8'd42, optNone, 9'h000);
      addStep(opPalCheck, 16'h0000, 8'd63, optNone, 9'h000);
      addStep(opWrite, portUlaplusSel, 8'hAA, optNone, 9'h000);
      addStep(opRead, portUlaplusSel, 8'h00, optNone, 9'h02A);
      addStep(opWrite, portUlaplusSel, 8'h40, optNone, 9'h000);
      addStep(opWrite, portUlaplusData, 8'h01, optNone, 9'h000);
      addStep(opRead, portUlaplusData, 8'h00, optNone, 9'h001);
      addStep(opRead, portUlaplusSel, 8'h00, optNone, 9'h040);
      addStep(opWrite, portUlaplusData, 8'h00, optNone, 9'h000);
      addStep(opRead, portUlaplusData, 8'h00, optNone, 9'h000);
      // ULAplus disabled
      addStep(opWrite, portUlaplusSel, 8'h05, optPlusDis, 9'h000);
      addStep(opRead, portUlaplusSel, 8'h00, optNone, 9'h040);
      addStep(opWrite, portUlaplusData, 8'h01, optPlusDis, 9'h000);
      addStep(opRead, portUlaplusData, 8'h00, optNone, 9'h000);
      addStep(opRead, portUlaplusSel, 8'h00, optPlusDis, 9'h0FF);
      addStep(opRead, portUlaplusData, 8'h00, optPlusDis, 9'h0FF);
      addStep(opWrite, portUlaplusSel, 8'h05, optNone, 9'h000);
      addStep(opWrite, portUlaplusData, 8'h99, optPlusDis, 9'h000);
      addStep(opPalCheck, 16'h0000, 8'd5, optNone, 9'h000);
      // Timex port
      addStep(opWrite, {8'h00, portTimex}, 8'hA5, optNone, 9'h000);
      addStep(opRead, {8'h00, portTimex}, 8'h00, optMmu, 9'h0A5);
      addStep(opRead, {8'h00, portTimex}, 8'h00, optNone, 9'h0FF);
      addStep(opDocExt, 16'h0000, 8'h00, optMmu, 9'h001);
      addStep(opDocExt, 16'h0000, 8'h00, optNone, 9'h000);
      addStep(opWrite, {8'h00, portTimex}, 8'h3C, optScrDis, 9'h000);
      addStep(opRead, {8'h00, portTimex}, 8'h00, optMmu, 9'h0A5);
      addStep(opWrite, {8'h12, portTimex}, 8'h3C, optNone, 9'h000);
      addStep(opRead, {8'h12, portTimex}, 8'h00, optMmu, 9'h03C);
      addStep(opDocExt, 16'h0000, 8'h00, optMmu, 9'h000);
      // Standard colours, attr in addr, pixel in data
      addStep(opColour, 16'h0007, 8'h01, optNone, 9'h16D);
      addStep(opColour, 16'h0007, 8'h00, optNone, 9'h000);
      addStep(opColour, 16'h0047, 8'h01, optNone, 9'h1FF);
      addStep(opColour, 16'h004A, 8'h01, optNone, 9'h038);
      addStep(opColour, 16'h004A, 8'h00, optNone, 9'h007);
      addStep(opColour, 16'h002C, 8'h00, optNone, 9'h145);
      addStep(opColour, 16'h002C, 8'h01, optNone, 9'h140);
      addStep(opColour, 16'h008E, 8'h01, optNone, 9'h168);
      addStep(opColour, 16'h008E, 8'h00, optNone, 9'h005);
      // Flash phase flips after 16 frames and back after 32
      addStep(opFrames, 16'h0000, 8'd16, optNone, 9'h000);
      addStep(opColour, 16'h008E, 8'h01, optNone, 9'h005);
      addStep(opColour, 16'h008E, 8'h00, optNone, 9'h168);
      addStep(opColour, 16'h000E, 8'h01, optNone, 9'h168);
      addStep(opFrames, 16'h0000, 8'd16, optNone, 9'h000);
      addStep(opColour, 16'h008E, 8'h01, optNone, 9'h168);
      addStep(opColour, 16'h008E, 8'h00, optNone, 9'h005);
      // ULAplus colours with flash phase high
      addStep(opWrite, portUlaplusSel, 8'h40, optNone, 9'h000);
      addStep(opWrite, portUlaplusData, 8'h01, optNone, 9'h000);
      addStep(opFrames, 16'h0000, 8'd16, optNone, 9'h000);
      addStep(opPlusColour, 16'h00C5, 8'h01, optNone, 9'h000);
      addStep(opPlusColour, 16'h00C5, 8'h00, optNone, 9'h000);
      addStep(opPlusColour, 16'h003A, 8'h01, optNone, 9'h000);
      addStep(opPlusColour, 16'h003A, 8'h00, optNone, 9'h000);
      addStep(opPlusColour, 16'h008E, 8'h01, optNone, 9'h000);
      addStep(opPlusColour, 16'h008E, 8'h00, optNone, 9'h000);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      stepT s;
      seed = 32'hd9f4b663;
      clkregs = 1'b0;
      rst_n = 1'b0;
      addr = '0;
      ioReqN = 1'b1;
      rdN = 1'b1;
      wrN = 1'b1;
      dataIn = '0;
      kbd = 5'h1F;
      ear = 1'b0;
      issue2Kbd = 1'b0;
      timexMmuEn = 1'b0;
      timexScrDis = 1'b0;
      ulaplusDis = 1'b0;
      frameStrobe = 1'b0;
      attr = '0;
      pixel = 1'b0;
      curOpts = optNone;
      buildTable();

      repeat (2) @(posedge clkregs);
      rst_n <= 1'b1;

      foreach (steps[i]) begin
         s = steps[i];
         curOpts = s.opts;
         case (s.op)
            opWrite: cpuCycle(s.addr, s.data, 1'b0, 1'b1);
            opRead: begin
               cpuCycle(s.addr, 8'h00, 1'b1, 1'b0);
               kbd <= s.data[4:0];
               ear <= s.data[5];
               @(negedge clkregs);
               checkByte("dataOut", dataOut, s.exp[7:0]);
            end
            opNoIo: begin
               cpuCycle(s.addr, 8'h00, 1'b0, 1'b0);
               @(negedge clkregs);
               checkByte("dataOut", dataOut, s.exp[7:0]);
            end
            opBorder: begin
               cpuCycle(16'h0000, 8'h00, 1'b0, 1'b0);
               @(negedge clkregs);
               checkBorder("border", border, s.exp[2:0]);
               checkBit("mic", mic, s.exp[3]);
               checkBit("spk", spk, s.exp[4]);
            end
            opDocExt: begin
               cpuCycle(16'h0000, 8'h00, 1'b0, 1'b0);
               @(negedge clkregs);
               checkBit("docExt", docExt, s.exp[0]);
            end
            opColour, opPlusColour: begin
               cpuCycle(16'h0000, 8'h00, 1'b0, 1'b0);
               attr <= s.addr[7:0];
               pixel <= s.data[0];
               // Output register adds one cycle
               cpuCycle(16'h0000, 8'h00, 1'b0, 1'b0);
               @(negedge clkregs);
               if (s.op == opColour)
                  checkColour("rgb", rgb, s.exp);
               else
                  checkColour("rgb", rgb, plusExpect(s.addr[7:0], s.data[0]));
            end
            opFrames: pulseFrames(int'(s.data));
            opPalFill: fillPalette();
            opPalCheck: begin
               cpuCycle(portUlaplusSel, s.data, 1'b0, 1'b1);
               cpuCycle(portUlaplusData, 8'h00, 1'b1, 1'b0);
               @(negedge clkregs);
               checkByte("dataOut", dataOut, palModel[s.data[5:0]]);
            end
            default: begin
               $display("Unknown operation in step %0d", i);
               $display("sim failed");
               $fatal(1, "bad table entry");
            end
         endcase
      end

      $display("sim passed");
      $finish;
   end

endmodule

// ==== project.f ====
hdl/ulaPkg.sv
hdl/ulaPortDecode.sv
hdl/ulaControlRegs.sv
hdl/ulaPaletteRam.sv
hdl/ulaColourOut.sv
hdl/ulaTop.sv
tb/ulaTb.sv

// ==== Bender.yml ====
package:
  name: ula_regs

sources:
  - files:
      - hdl/ulaPkg.sv
      - hdl/ulaPortDecode.sv
      - hdl/ulaControlRegs.sv
      - hdl/ulaPaletteRam.sv
      - hdl/ulaColourOut.sv
      - hdl/ulaTop.sv
  - target: simulation
    files:
      - tb/ulaTb.sv
